//--- Makefile
VERILATOR ?= verilator
TOP       ?= lce_req_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
verilog/lce_pkg.sv
verilog/lce_cfg_regs.sv
verilog/req_two_fifo.sv
verilog/req_stream_pump.sv
verilog/lce_req_fsm.sv
verilog/lce_req_top.sv
sim/lce_req_tb.sv

//--- sim/lce_req_tb.sv
// testbench for the lce request engine
// drives cache requests, metadata and config writes, models the cce end
// of the network stream and checks every beat against a reference header
`timescale 1ns/10ps

module lce_req_tb;
  import lce_pkg::*;

  localparam int CREDITS      = 4;
  localparam int NUM_CCE      = 3;
  localparam int NUM_NORMAL   = 30;
  localparam int NUM_UNCACHED = 10;
  localparam int NUM_HELD     = CREDITS + 2;
  localparam int NUM_TESTS    = NUM_NORMAL + NUM_UNCACHED + NUM_HELD;
  localparam int TIMEOUT_NS   = NUM_TESTS * 200;

  logic          clk_i = 1'b0;
  logic          reset_i;
  logic          cache_init_done_i;
  logic          cfg_w_v_i;
  cfg_addr_e     cfg_addr_i;
  logic [7:0]    cfg_data_i;
  cache_req_s    cache_req_i;
  logic          cache_req_v_i;
  logic          cache_req_ready_o;
  cache_meta_s   cache_meta_i;
  logic          cache_meta_v_i;
  logic          credit_return_i;
  logic          req_done_i;
  lce_req_beat_s lce_req_o;
  logic          lce_req_v_o;
  logic          lce_req_ready_i;
  logic          credits_full_o;
  logic          credits_empty_o;
  logic          busy_o;

  integer        seed = 32'h47b13aee;
  lce_req_beat_s exp_q[$];
  lce_req_beat_s exp_beat;
  lce_req_beat_s stall_beat;
  logic          stall_v = 1'b0;
  logic          hold_credits;
  int            hdr_count = 0;
  int            hdr_base;
  int            credits_given = 0;
  int            done_needed = 0;
  int            done_given = 0;
  int            blocking_accepted;
  int            credit_wait;
  int            done_wait;
  logic [3:0]    cfg_id;
  logic [2:0]    cfg_did;
  lce_mode_e     cfg_mode;
  logic          cfg_sync;

  always #2 clk_i = ~clk_i;

  lce_req_top #(.CREDITS(CREDITS), .NUM_CCE(NUM_CCE)) uut (
    .clk_i(clk_i), .reset_i(reset_i), .cache_init_done_i(cache_init_done_i),
    .cfg_w_v_i(cfg_w_v_i), .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i),
    .cache_req_i(cache_req_i), .cache_req_v_i(cache_req_v_i),
    .cache_req_ready_o(cache_req_ready_o),
    .cache_meta_i(cache_meta_i), .cache_meta_v_i(cache_meta_v_i),
    .credit_return_i(credit_return_i), .req_done_i(req_done_i),
    .lce_req_o(lce_req_o), .lce_req_v_o(lce_req_v_o), .lce_req_ready_i(lce_req_ready_i),
    .credits_full_o(credits_full_o), .credits_empty_o(credits_empty_o), .busy_o(busy_o)
  );

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "first error reached");
    end
  endtask

  // reference header for a request under the current config
  function automatic lce_req_header_s expected_header(input cache_req_s req,
                                                      input logic [2:0] way);
    lce_req_header_s h;
    logic            normal;
    h        = '0;
    normal   = (cfg_mode == e_lce_mode_normal);
    h.size   = req.size;
    h.addr   = req.addr;
    h.src_id = cfg_id;
    h.src_did = cfg_did;
    h.dst_id = 2'((req.addr >> 6) % NUM_CCE);
    case (req.msg_type)
      e_miss_load:
      begin
        h.msg_type = normal ? e_net_rd_miss : e_net_uc_rd;
        h.lru_way  = way;
      end
      e_miss_store:
      begin
        h.msg_type = normal ? e_net_wr_miss : e_net_uc_rd;
        h.lru_way  = way;
      end
      e_uc_load: h.msg_type = e_net_uc_rd;
      e_uc_store:
      begin
        h.msg_type = e_net_uc_wr;
        h.has_data = 1'b1;
      end
      default:
      begin
        h.msg_type = e_net_uc_amo;
        h.subop    = req.subop;
        h.has_data = 1'b1;
      end
    endcase
    return h;
  endfunction

  task automatic push_expected(input cache_req_s req, input logic [2:0] way);
    lce_req_beat_s   b;
    lce_req_header_s h;
    h             = expected_header(req, way);
    b             = '0;
    b.last        = ~h.has_data;
    b.word.header = h;
    exp_q.push_back(b);
    if (h.has_data)
    begin
      b           = '0;
      b.is_data   = 1'b1;
      b.last      = 1'b1;
      b.word.data = req.data;
      exp_q.push_back(b);
    end
  endtask

  task automatic make_request(input lce_req_type_e t, output cache_req_s req);
    req.msg_type = t;
    req.subop    = lce_amo_subop_e'(4'($unsigned($random(seed)) % 12));
    req.size     = 3'($random(seed));
    req.addr     = $random(seed);
    req.data     = {$random(seed), $random(seed)};
  endtask

  // offer one request, then the metadata pulse meta_delay cycles later
  task automatic send_request(input cache_req_s req, input logic [2:0] way,
                              input int meta_delay);
    logic miss;
    logic taken;
    miss                 = req.msg_type inside {e_miss_load, e_miss_store};
    cache_req_i          = req;
    cache_meta_i.lru_way = way;
    @(negedge clk_i);
    while (!cache_req_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    cache_req_v_i  = 1'b1;
    cache_meta_v_i = miss & (meta_delay == 0);
    taken          = 1'b0;
    while (!taken)
    begin
      @(negedge clk_i);
      taken = cache_req_ready_o;
      if (taken)
      begin
        if (req.msg_type != e_uc_store)
        begin
          check_value(128'(blocking_accepted - done_given), 128'(0),
                      "blocking request accepted before completion");
          blocking_accepted++;
        end
        push_expected(req, way);
      end
      @(posedge clk_i);
      #1;
      cache_meta_v_i = 1'b0;
    end
    cache_req_v_i = 1'b0;
    if (miss && meta_delay > 0)
    begin
      repeat (meta_delay - 1)
      begin
        @(posedge clk_i);
        #1;
      end
      cache_meta_v_i = 1'b1;
      @(posedge clk_i);
      #1;
      cache_meta_v_i = 1'b0;
    end
  endtask

  task automatic run_random(input int count);
    cache_req_s req;
    logic [2:0] way;
    int         i;
    for (i = 0; i < count; i++)
    begin
      make_request(lce_req_type_e'(3'($unsigned($random(seed)) % 5)), req);
      way = 3'($random(seed));
      send_request(req, way, $unsigned($random(seed)) % 6);
    end
  endtask

  task automatic run_stores(input int count);
    cache_req_s req;
    int         i;
    for (i = 0; i < count; i++)
    begin
      make_request(e_uc_store, req);
      send_request(req, 3'd0, 0);
    end
  endtask

  task automatic cfg_write(input cfg_addr_e addr, input logic [7:0] data);
    @(posedge clk_i);
    #1;
    cfg_w_v_i  = 1'b1;
    cfg_addr_i = addr;
    cfg_data_i = data;
    case (addr)
      e_cfg_lce_id: cfg_id   = data[3:0];
      e_cfg_did:    cfg_did  = data[2:0];
      e_cfg_mode:   cfg_mode = lce_mode_e'(data[0]);
      default:      cfg_sync = data[0];
    endcase
    @(posedge clk_i);
    #1;
    cfg_w_v_i = 1'b0;
    @(negedge clk_i);
    check_value(128'(busy_o), 128'((cfg_mode == e_lce_mode_normal) & ~cfg_sync),
                "busy after config write");
    @(posedge clk_i);
    #1;
  endtask

  // wait until every beat is seen and the cce has answered everything
  task automatic drain();
    while (exp_q.size() != 0 || credits_given != hdr_count || done_given != done_needed)
      @(negedge clk_i);
    repeat (3)
      @(negedge clk_i);
    check_value(128'(credits_empty_o), 128'(1'b1), "credits empty after drain");
    @(posedge clk_i);
    #1;
  endtask

  // cce model with random ready, delayed credit returns and completions
  initial
  begin
    lce_req_ready_i = 1'b0;
    credit_return_i = 1'b0;
    req_done_i      = 1'b0;
    credit_wait     = 0;
    done_wait       = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      lce_req_ready_i = ($unsigned($random(seed)) % 4) != 0;
      credit_return_i = 1'b0;
      req_done_i      = 1'b0;
      if (credits_given < hdr_count && !hold_credits)
      begin
        if (credit_wait == 0)
        begin
          credit_return_i = 1'b1;
          credits_given++;
          credit_wait = $unsigned($random(seed)) % 4;
        end
        else
          credit_wait--;
      end
      if (done_given < done_needed)
      begin
        if (done_wait == 0)
        begin
          req_done_i = 1'b1;
          done_given++;
          done_wait = $unsigned($random(seed)) % 5;
        end
        else
          done_wait--;
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      if (stall_v)
      begin
        check_value(128'(lce_req_v_o), 128'(1'b1), "valid dropped under stall");
        check_value(128'(lce_req_o), 128'(stall_beat), "beat changed under stall");
      end
      stall_v    = lce_req_v_o & ~lce_req_ready_i;
      stall_beat = lce_req_o;
      if (lce_req_v_o & lce_req_ready_i)
      begin
        if (exp_q.size() == 0)
        begin
          $display("unexpected beat on the request stream at %0t", $time);
          $display("Simulation FAILED");
          $fatal(1, "beat without a request");
        end
        exp_beat = exp_q.pop_front();
        check_value(128'(lce_req_o), 128'(exp_beat), "request beat");
        if (!lce_req_o.is_data)
        begin
          hdr_count++;
          if (lce_req_o.word.header.msg_type != e_net_uc_wr)
            done_needed++;
          check_value(128'(hdr_count - credits_given <= CREDITS), 128'(1'b1),
                      "headers beyond the credit limit");
        end
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    reset_i           = 1'b1;
    cache_init_done_i = 1'b0;
    cfg_w_v_i         = 1'b0;
    cfg_addr_i        = e_cfg_lce_id;
    cfg_data_i        = 8'h00;
    cache_req_i       = '0;
    cache_req_v_i     = 1'b0;
    cache_meta_i      = '0;
    cache_meta_v_i    = 1'b0;
    hold_credits      = 1'b0;
    blocking_accepted = 0;
    cfg_id            = '0;
    cfg_did           = '0;
    cfg_mode          = e_lce_mode_uncached;
    cfg_sync          = 1'b0;
    repeat (3)
      @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value(128'(cache_req_ready_o), 128'(1'b0), "ready before init done");
    check_value(128'(lce_req_v_o), 128'(1'b0), "stream valid after reset");
    check_value(128'(busy_o), 128'(1'b0), "busy after reset");
    @(posedge clk_i);
    #1;
    cache_init_done_i = 1'b1;

    cfg_write(e_cfg_lce_id, 8'h5b);
    cfg_write(e_cfg_did, 8'h06);
    cfg_write(e_cfg_mode, 8'h01);
    cfg_write(e_cfg_sync, 8'h01);
    cfg_write(e_cfg_sync, 8'h00);
    cfg_write(e_cfg_sync, 8'h01);

    // normal mode traffic, then uncached mode traffic
    run_random(NUM_NORMAL);
    drain();
    cfg_write(e_cfg_mode, 8'h00);
    run_random(NUM_UNCACHED);
    drain();

    hold_credits = 1'b1;
    hdr_base     = hdr_count;
    fork
      run_stores(NUM_HELD);
      begin
        while (!credits_full_o)
          @(negedge clk_i);
        repeat (20)
          @(negedge clk_i);
        check_value(128'(hdr_count - hdr_base), 128'(CREDITS), "headers with credits held");
        check_value(128'(credits_full_o), 128'(1'b1), "credits full while held");
        hold_credits = 1'b0;
      end
    join
    drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog/lce_cfg_regs.sv
// lce configuration registers
// holds the lce id, domain id, mode and sync flag, written one field
// per cycle over a small write port, and derives the busy indication
`timescale 1ns/10ps

module lce_cfg_regs (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                cfg_w_v_i,
  input  lce_pkg::cfg_addr_e                  cfg_addr_i,
  input  logic [7:0]                          cfg_data_i,
  output logic [lce_pkg::lce_id_width_gp-1:0] lce_id_o,
  output logic [lce_pkg::lce_did_width_gp-1:0] did_o,
  output lce_pkg::lce_mode_e                  mode_o,
  output logic                                sync_done_o,
  output logic                                busy_o
);
  import lce_pkg::*;

  logic [lce_id_width_gp-1:0]  lce_id_r;
  logic [lce_did_width_gp-1:0] did_r;
  lce_mode_e                   mode_r;
  logic                        sync_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lce_id_r <= '0;
      did_r    <= '0;
      mode_r   <= e_lce_mode_uncached;
      sync_r   <= 1'b0;
    end
    else if (cfg_w_v_i)
    begin
      case (cfg_addr_i)
        e_cfg_lce_id: lce_id_r <= cfg_data_i[lce_id_width_gp-1:0];
        e_cfg_did:    did_r    <= cfg_data_i[lce_did_width_gp-1:0];
        e_cfg_mode:   mode_r   <= lce_mode_e'(cfg_data_i[0]);
        default:      sync_r   <= cfg_data_i[0];
      endcase
    end
  end

  assign lce_id_o    = lce_id_r;
  assign did_o       = did_r;
  assign mode_o      = mode_r;
  assign sync_done_o = sync_r;

  // normal mode needs the cce handshake before requests may go out
  assign busy_o = (mode_r == e_lce_mode_normal) & ~sync_r;

endmodule

//--- verilog/lce_pkg.sv
// lce request engine shared definitions
// cache request, metadata, network header and stream beat formats
// for the path from the local cache engine to the directory controller
package lce_pkg;

  localparam int lce_paddr_width_gp  = 32;
  localparam int lce_fill_width_gp   = 64;
  localparam int lce_id_width_gp     = 4;
  localparam int lce_did_width_gp    = 3;
  localparam int lce_cce_id_width_gp = 2;
  localparam int lce_way_width_gp    = 3;
  // 64-byte coherence blocks
  localparam int lce_block_offset_gp = 6;

  typedef enum logic [2:0] {
    e_miss_load, e_miss_store, e_uc_load, e_uc_store, e_uc_amo
  } lce_req_type_e;

  typedef enum logic [3:0] {
    e_amo_store, e_amo_lr, e_amo_sc, e_amo_swap, e_amo_add, e_amo_xor,
    e_amo_and, e_amo_or, e_amo_min, e_amo_max, e_amo_minu, e_amo_maxu
  } lce_amo_subop_e;

  typedef enum logic [2:0] {
    e_net_rd_miss, e_net_wr_miss, e_net_uc_rd, e_net_uc_wr, e_net_uc_amo
  } lce_net_msg_e;

  typedef enum logic {
    e_lce_mode_uncached = 1'b0,
    e_lce_mode_normal   = 1'b1
  } lce_mode_e;

  typedef struct packed {
    lce_req_type_e                 msg_type;
    lce_amo_subop_e                subop;
    logic [2:0]                    size;
    logic [lce_paddr_width_gp-1:0] addr;
    logic [lce_fill_width_gp-1:0]  data;
  } cache_req_s;

  typedef struct packed {
    logic [lce_way_width_gp-1:0] lru_way;
  } cache_meta_s;

  // header fills one 64-bit network word, pad sits at the top
  typedef struct packed {
    logic [8:0]                     pad;
    lce_net_msg_e                   msg_type;
    lce_amo_subop_e                 subop;
    logic [2:0]                     size;
    logic [lce_paddr_width_gp-1:0]  addr;
    logic [lce_id_width_gp-1:0]     src_id;
    logic [lce_cce_id_width_gp-1:0] dst_id;
    logic [lce_did_width_gp-1:0]    src_did;
    logic [lce_way_width_gp-1:0]    lru_way;
    logic                           has_data;
  } lce_req_header_s;

  typedef union packed {
    lce_req_header_s               header;
    logic [lce_fill_width_gp-1:0]  data;
  } lce_req_word_u;

  typedef struct packed {
    logic          is_data;
    logic          last;
    lce_req_word_u word;
  } lce_req_beat_s;

  typedef enum logic [1:0] {
    e_cfg_lce_id, e_cfg_did, e_cfg_mode, e_cfg_sync
  } cfg_addr_e;

endpackage

//--- verilog/lce_req_fsm.sv
// lce request control
// decodes queued cache requests into network headers, maps the block
// address to a cce, counts outstanding message credits and sequences
// blocking requests, uncached stores go out whenever the pump is free
`timescale 1ns/10ps

module lce_req_fsm #(
  parameter int CREDITS = 4,
  parameter int NUM_CCE = 2
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   cache_init_done_i,
  input  logic [lce_pkg::lce_id_width_gp-1:0]    lce_id_i,
  input  logic [lce_pkg::lce_did_width_gp-1:0]   did_i,
  input  lce_pkg::lce_mode_e                     mode_i,
  input  lce_pkg::cache_req_s                    req_i,
  input  logic                                   req_v_i,
  output logic                                   req_yumi_o,
  input  lce_pkg::cache_meta_s                   meta_i,
  input  logic                                   meta_v_i,
  output logic                                   meta_yumi_o,
  output logic                                   req_accept_ok_o,
  input  logic                                   credit_return_i,
  input  logic                                   req_done_i,
  output lce_pkg::lce_req_header_s               hdr_o,
  output logic [lce_pkg::lce_fill_width_gp-1:0]  data_o,
  output logic                                   pump_v_o,
  input  logic                                   pump_ready_i,
  input  logic                                   sent_i,
  output logic                                   credits_full_o,
  output logic                                   credits_empty_o
);
  import lce_pkg::*;

  localparam int CRED_W = $clog2(CREDITS + 1);

  typedef enum logic [1:0] {e_reset, e_ready, e_send, e_wait_done} fsm_state_e;

  fsm_state_e                               state_r;
  fsm_state_e                               state_n;
  logic [CRED_W-1:0]                        credit_cnt_r;
  logic                                     is_miss;
  logic                                     is_uc_store;
  logic                                     is_blocking;
  logic                                     pump_fire;
  logic [lce_paddr_width_gp-lce_block_offset_gp-1:0] block_num;

  assign is_miss     = req_i.msg_type inside {e_miss_load, e_miss_store};
  assign is_uc_store = (req_i.msg_type == e_uc_store);
  assign is_blocking = ~is_uc_store;
  assign pump_fire   = pump_v_o & pump_ready_i;
  assign block_num   = req_i.addr[lce_paddr_width_gp-1:lce_block_offset_gp];

  always_comb
  begin
    hdr_o          = '0;
    hdr_o.size     = req_i.size;
    hdr_o.addr     = req_i.addr;
    hdr_o.src_id   = lce_id_i;
    hdr_o.src_did  = did_i;
    // blocks interleave across cces
    hdr_o.dst_id   = lce_cce_id_width_gp'(block_num % NUM_CCE);
    hdr_o.lru_way  = is_miss ? meta_i.lru_way : '0;
    hdr_o.has_data = req_i.msg_type inside {e_uc_store, e_uc_amo};
    hdr_o.subop    = (req_i.msg_type == e_uc_amo) ? req_i.subop : e_amo_store;
    case (req_i.msg_type)
      // in uncached mode a miss fetches without taking ownership
      e_miss_load:
        hdr_o.msg_type = (mode_i == e_lce_mode_normal) ? e_net_rd_miss : e_net_uc_rd;
      e_miss_store:
        hdr_o.msg_type = (mode_i == e_lce_mode_normal) ? e_net_wr_miss : e_net_uc_rd;
      e_uc_store: hdr_o.msg_type = e_net_uc_wr;
      e_uc_amo:   hdr_o.msg_type = e_net_uc_amo;
      default:    hdr_o.msg_type = e_net_uc_rd;
    endcase
  end

  assign data_o = req_i.data;

  always_comb
  begin
    state_n     = state_r;
    pump_v_o    = 1'b0;
    req_yumi_o  = 1'b0;
    meta_yumi_o = 1'b0;

    case (state_r)
      e_reset:
        if (cache_init_done_i)
          state_n = e_ready;
      e_ready:
        if (req_v_i & is_blocking)
          state_n = e_send;
      e_send:
      begin
        // misses wait for their replacement way
        pump_v_o = ~credits_full_o & (~is_miss | meta_v_i);
        if (pump_fire)
        begin
          req_yumi_o  = 1'b1;
          meta_yumi_o = is_miss;
          state_n     = e_wait_done;
        end
      end
      default:
        if (req_done_i)
          state_n = e_ready;
    endcase

    // uncached stores need no completion, send whenever possible
    if ((state_r inside {e_ready, e_wait_done}) & req_v_i & is_uc_store)
    begin
      pump_v_o   = ~credits_full_o;
      req_yumi_o = pump_fire;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r      <= e_reset;
      credit_cnt_r <= '0;
    end
    else
    begin
      state_r      <= state_n;
      credit_cnt_r <= credit_cnt_r + CRED_W'(sent_i) - CRED_W'(credit_return_i);
    end
  end

  // a blocking request may only enter an empty queue while idle
  assign req_accept_ok_o = (state_r == e_ready) & ~req_v_i;
  assign credits_full_o  = (credit_cnt_r == CRED_W'(CREDITS));
  assign credits_empty_o = (credit_cnt_r == '0) & ~req_v_i;

  credit_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_cnt_r <= CRED_W'(CREDITS))
    else $error("credit count above limit");

endmodule

//--- verilog/lce_req_top.sv
// lce request engine top level
// config registers, request and metadata queues, request control and
// the network stream serializer
`timescale 1ns/10ps

module lce_req_top #(
  parameter int CREDITS = 4,
  parameter int NUM_CCE = 2
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   cache_init_done_i,
  input  logic                   cfg_w_v_i,
  input  lce_pkg::cfg_addr_e     cfg_addr_i,
  input  logic [7:0]             cfg_data_i,
  input  lce_pkg::cache_req_s    cache_req_i,
  input  logic                   cache_req_v_i,
  output logic                   cache_req_ready_o,
  input  lce_pkg::cache_meta_s   cache_meta_i,
  input  logic                   cache_meta_v_i,
  input  logic                   credit_return_i,
  input  logic                   req_done_i,
  output lce_pkg::lce_req_beat_s lce_req_o,
  output logic                   lce_req_v_o,
  input  logic                   lce_req_ready_i,
  output logic                   credits_full_o,
  output logic                   credits_empty_o,
  output logic                   busy_o
);
  import lce_pkg::*;

  logic [lce_id_width_gp-1:0]   lce_id;
  logic [lce_did_width_gp-1:0]  did;
  lce_mode_e                    mode;
  cache_req_s                   req_head;
  logic                         req_head_v, req_yumi, req_fifo_ready;
  cache_meta_s                  meta_head;
  logic                         meta_head_v, meta_yumi, meta_fifo_ready;
  logic                         req_accept_ok;
  lce_req_header_s              pump_hdr;
  logic [lce_fill_width_gp-1:0] pump_data;
  logic                         pump_v, pump_ready, pump_sent;

  // stores slip past an outstanding blocking request
  assign cache_req_ready_o = req_fifo_ready & meta_fifo_ready & cache_init_done_i
                           & (req_accept_ok | (cache_req_i.msg_type == e_uc_store));

  lce_cfg_regs cfg_regs (
    .clk_i(clk_i), .reset_i(reset_i),
    .cfg_w_v_i(cfg_w_v_i), .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i),
    .lce_id_o(lce_id), .did_o(did), .mode_o(mode),
    .sync_done_o(), .busy_o(busy_o)
  );

  req_two_fifo #(.WIDTH($bits(cache_req_s))) req_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(cache_req_i), .v_i(cache_req_v_i & cache_req_ready_o), .ready_o(req_fifo_ready),
    .data_o(req_head), .v_o(req_head_v), .yumi_i(req_yumi)
  );

  req_two_fifo #(.WIDTH($bits(cache_meta_s))) meta_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(cache_meta_i), .v_i(cache_meta_v_i), .ready_o(meta_fifo_ready),
    .data_o(meta_head), .v_o(meta_head_v), .yumi_i(meta_yumi)
  );

  lce_req_fsm #(.CREDITS(CREDITS), .NUM_CCE(NUM_CCE)) req_fsm (
    .clk_i(clk_i), .reset_i(reset_i), .cache_init_done_i(cache_init_done_i),
    .lce_id_i(lce_id), .did_i(did), .mode_i(mode),
    .req_i(req_head), .req_v_i(req_head_v), .req_yumi_o(req_yumi),
    .meta_i(meta_head), .meta_v_i(meta_head_v), .meta_yumi_o(meta_yumi),
    .req_accept_ok_o(req_accept_ok),
    .credit_return_i(credit_return_i), .req_done_i(req_done_i),
    .hdr_o(pump_hdr), .data_o(pump_data), .pump_v_o(pump_v),
    .pump_ready_i(pump_ready), .sent_i(pump_sent),
    .credits_full_o(credits_full_o), .credits_empty_o(credits_empty_o)
  );

  req_stream_pump req_pump (
    .clk_i(clk_i), .reset_i(reset_i),
    .header_i(pump_hdr), .data_i(pump_data), .v_i(pump_v), .ready_o(pump_ready),
    .lce_req_o(lce_req_o), .lce_req_v_o(lce_req_v_o), .lce_req_ready_i(lce_req_ready_i),
    .sent_o(pump_sent)
  );

endmodule

//--- verilog/req_stream_pump.sv
// request stream serializer
// takes one formatted request, then drives a header beat and, for
// messages with a payload, one data beat onto the network stream
`timescale 1ns/10ps

module req_stream_pump (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  lce_pkg::lce_req_header_s              header_i,
  input  logic [lce_pkg::lce_fill_width_gp-1:0] data_i,
  input  logic                                  v_i,
  output logic                                  ready_o,
  output lce_pkg::lce_req_beat_s                lce_req_o,
  output logic                                  lce_req_v_o,
  input  logic                                  lce_req_ready_i,
  output logic                                  sent_o
);
  import lce_pkg::*;

  typedef enum logic [1:0] {e_idle, e_header, e_data} pump_state_e;

  pump_state_e                  state_r;
  pump_state_e                  state_n;
  lce_req_header_s              header_r;
  logic [lce_fill_width_gp-1:0] data_r;
  logic                         beat_fire;

  // one message in flight at a time
  assign ready_o     = (state_r == e_idle);
  assign lce_req_v_o = (state_r != e_idle);
  assign beat_fire   = lce_req_v_o & lce_req_ready_i;
  assign sent_o      = beat_fire & (state_r == e_header);

  always_comb
  begin
    lce_req_o = '0;
    if (state_r == e_data)
    begin
      lce_req_o.is_data   = 1'b1;
      lce_req_o.last      = 1'b1;
      lce_req_o.word.data = data_r;
    end
    else
    begin
      lce_req_o.last        = ~header_r.has_data;
      lce_req_o.word.header = header_r;
    end
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (v_i)
          state_n = e_header;
      e_header:
        if (beat_fire)
          state_n = header_r.has_data ? e_data : e_idle;
      default:
        if (beat_fire)
          state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i & ready_o)
    begin
      header_r <= header_i;
      data_r   <= data_i;
    end
  end

  // a stalled beat must not change under the receiver
  beat_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_v_o & ~lce_req_ready_i |=> lce_req_v_o & $stable(lce_req_o))
    else $error("request beat changed while stalled");

endmodule

//--- verilog/req_two_fifo.sv
// two-entry request queue
// ring of two slots with valid/ready on the input and valid/yumi on the
// output, data appears at the output the cycle after it is pushed
`timescale 1ns/10ps

module req_two_fifo #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             v_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             v_o,
  input  logic             yumi_i
);

  logic [WIDTH-1:0] mem_r [2];
  logic             wptr_r;
  logic             rptr_r;
  logic [1:0]       count_r;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (v_i)
        wptr_r <= ~wptr_r;
      if (yumi_i)
        rptr_r <= ~rptr_r;
      count_r <= count_r + {1'b0, v_i} - {1'b0, yumi_i};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
      mem_r[wptr_r] <= data_i;
  end

  push_when_full_a: assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> ready_o)
    else $error("push into a full queue");

  pop_when_empty_a: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("pop from an empty queue");

endmodule
